// ==== hdl/core6809_pkg.sv ====
// 6809 core subset shared definitions
// Bus widths, condition code layout, opcode rows and ALU op codes,
// fetch states and the request structs passed between units
`default_nettype none

package core6809_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;

  // ------------------------------------------------------------
  // Condition code register
  // ------------------------------------------------------------
  localparam logic [2:0] CC_E = 3'd7;  // Entire state stacked
  localparam logic [2:0] CC_F = 3'd6;  // FIRQ mask
  localparam logic [2:0] CC_H = 3'd5;  // Half carry
  localparam logic [2:0] CC_I = 3'd4;  // IRQ mask
  localparam logic [2:0] CC_N = 3'd3;  // Negative
  localparam logic [2:0] CC_Z = 3'd2;  // Zero
  localparam logic [2:0] CC_V = 3'd1;  // Overflow
  localparam logic [2:0] CC_C = 3'd0;  // Carry / borrow

  // Interrupts masked out of reset
  localparam byte_t CC_RESET     = 8'h50;
  localparam addr_t RESET_VECTOR = 16'hFFFE;

  // Whole-byte opcodes
  localparam byte_t OP_STA_EXT = 8'hB7;
  localparam byte_t OP_STB_EXT = 8'hF7;
  localparam byte_t OP_NOP     = 8'h12;

  // Opcode rows, upper nibble
  localparam logic [3:0] ROW_BRANCH = 4'h2;
  localparam logic [3:0] ROW_INH_A  = 4'h4;
  localparam logic [3:0] ROW_INH_B  = 4'h5;
  localparam logic [3:0] ROW_IMM_A  = 4'h8;
  localparam logic [3:0] ROW_IMM_B  = 4'hC;
  localparam logic [3:0] ROW_EXT_A  = 4'hB;
  localparam logic [3:0] ROW_EXT_B  = 4'hF;

  // Immediate row ops, lower nibble
  localparam logic [3:0] ALU_SUB = 4'h0;
  localparam logic [3:0] ALU_SBC = 4'h2;
  localparam logic [3:0] ALU_AND = 4'h4;
  localparam logic [3:0] ALU_LD  = 4'h6;
  localparam logic [3:0] ALU_EOR = 4'h8;
  localparam logic [3:0] ALU_ADC = 4'h9;
  localparam logic [3:0] ALU_OR  = 4'hA;
  localparam logic [3:0] ALU_ADD = 4'hB;

  // Inherent row ops, lower nibble
  localparam logic [3:0] INH_NEG = 4'h0;
  localparam logic [3:0] INH_COM = 4'h3;
  localparam logic [3:0] INH_LSR = 4'h4;
  localparam logic [3:0] INH_DEC = 4'hA;
  localparam logic [3:0] INH_INC = 4'hC;
  localparam logic [3:0] INH_TST = 4'hD;
  localparam logic [3:0] INH_CLR = 4'hF;

  // ------------------------------------------------------------
  // One-hot fetch states
  // ------------------------------------------------------------
  typedef enum logic [4:0] {
    ST_FETCH_WAIT   = 5'b0_0001,  // Reset vector in flight
    ST_FETCH_IR     = 5'b0_0010,  // Opcode byte
    ST_FETCH_PB_IMM = 5'b0_0100,  // Immediate, offset or address MSB
    ST_FETCH_B2     = 5'b0_1000,  // Address LSB
    ST_FETCH_B3     = 5'b1_0000   // Bus lent out for the store
  } fetch_state_t;

  // Opcode byte, split per decoder
  typedef struct packed {
    logic [3:0] row;
    logic [3:0] op;
  } alu_view_t;

  typedef struct packed {
    logic [3:0] cls;
    logic [3:0] cond;
  } branch_view_t;

  typedef union packed {
    alu_view_t    alu;
    branch_view_t branch;
  } opcode_u;

  typedef struct packed {
    logic    valid;
    opcode_u opcode;
    byte_t   operand;
  } exec_req_t;

  typedef struct packed {
    logic  valid;
    logic  use_b;
    addr_t ea;
  } store_req_t;

  typedef struct packed {
    logic h;
    logic n;
    logic z;
    logic v;
    logic c;
  } alu_flags_t;

endpackage

`default_nettype wire

// ==== hdl/alu8.sv ====
// 8-bit ALU in 6809 opcode encoding
// One shared adder covers add, subtract, negate, INC and DEC
// Flags not defined by an op keep their CC value
`default_nettype none

module alu8 import core6809_pkg::*; (
  input  wire byte_t    in_a,
  input  wire byte_t    in_b,
  input  wire opcode_u  opcode,
  input  wire byte_t    cc_in,
  output byte_t         result,
  output alu_flags_t    flags
);

  logic [3:0] op;
  logic       is_inh;
  byte_t      add_x;
  byte_t      add_y;
  logic       add_ci;
  logic [8:0] sum;
  logic       add_v;
  logic       half;
  byte_t      res;
  logic       h;
  logic       v;
  logic       c;

  assign op     = opcode.alu.op;
  assign is_inh = opcode.alu.row inside {ROW_INH_A, ROW_INH_B};

  // ------------------------------------------------------------
  // Adder operands, subtract as add of the complement
  // ------------------------------------------------------------
  always_comb begin
    add_x  = in_a;
    add_y  = in_b;
    add_ci = 1'b0;
    if (is_inh) begin
      case (op)
        INH_NEG: begin
          add_x  = 8'h00;
          add_y  = ~in_a;
          add_ci = 1'b1;
        end
        INH_DEC: add_y = 8'hFF;
        INH_INC: begin
          add_y  = 8'h00;
          add_ci = 1'b1;
        end
        default: ;
      endcase
    end else begin
      case (op)
        ALU_SUB: begin
          add_y  = ~in_b;
          add_ci = 1'b1;
        end
        ALU_SBC: begin
          add_y  = ~in_b;
          add_ci = ~cc_in[CC_C];
        end
        ALU_ADC: add_ci = cc_in[CC_C];
        default: ;
      endcase
    end
  end

  assign sum   = {1'b0, add_x} + {1'b0, add_y} + {8'h00, add_ci};
  // Same-sign inputs, result sign flipped
  assign add_v = (add_x[7] == add_y[7]) && (sum[7] != add_x[7]);
  assign half  = add_x[4] ^ add_y[4] ^ sum[4];

  always_comb begin
    res = sum[7:0];
    h   = cc_in[CC_H];
    v   = add_v;
    c   = cc_in[CC_C];
    if (is_inh) begin
      case (op)
        INH_NEG: c = ~sum[8];  // Borrow, set for any nonzero input
        INH_COM: begin
          res = ~in_a;
          v   = 1'b0;
          c   = 1'b1;
        end
        INH_LSR: begin
          res = {1'b0, in_a[7:1]};
          v   = cc_in[CC_V];
          c   = in_a[0];
        end
        INH_DEC, INH_INC: ;
        INH_TST: begin
          res = in_a;
          v   = 1'b0;
        end
        INH_CLR: begin
          res = 8'h00;
          v   = 1'b0;
          c   = 1'b0;
        end
        default: begin
          res = in_a;
          v   = cc_in[CC_V];
        end
      endcase
    end else begin
      case (op)
        ALU_SUB, ALU_SBC: c = ~sum[8];
        ALU_ADD, ALU_ADC: begin
          c = sum[8];
          h = half;
        end
        ALU_AND: begin
          res = in_a & in_b;
          v   = 1'b0;
        end
        ALU_OR: begin
          res = in_a | in_b;
          v   = 1'b0;
        end
        ALU_EOR: begin
          res = in_a ^ in_b;
          v   = 1'b0;
        end
        ALU_LD: begin
          res = in_b;
          v   = 1'b0;
        end
        default: begin
          res = in_a;
          v   = cc_in[CC_V];
        end
      endcase
    end
  end

  assign result = res;
  assign flags  = '{h: h, n: res[7], z: (res == 8'h00), v: v, c: c};

endmodule

`default_nettype wire

// ==== hdl/fetch_ctrl.sv ====
// Instruction fetch and branch control
// One-hot fetch FSM with IR, post-byte and byte-2 registers
// Owns the PC and resolves short branches against CC
`default_nettype none

module fetch_ctrl import core6809_pkg::*; (
  input  wire          clk,
  input  wire          reset_b,
  input  wire byte_t   din,
  input  wire          bus_busy,
  input  wire          vector_load,
  input  wire addr_t   vector,
  input  wire byte_t   cc,
  output addr_t        pc,
  output exec_req_t    exec_req,
  output store_req_t   store_req
);

  fetch_state_t state_q;
  fetch_state_t state_next;
  opcode_u      din_u;
  opcode_u      ir_q;
  byte_t        pb_q;
  byte_t        fetch2_q;
  addr_t        pc_q;
  addr_t        pc_inc;
  addr_t        pc_branch;
  logic         exec_valid_q;
  logic         fetch_en;
  logic         fc_alu_inh;
  logic         fc_two;
  logic         fc_store;
  logic         ir_alu_imm;
  logic         ir_store;
  logic         br_flag;
  logic         br_known;
  logic         br_taken;

  assign din_u    = din;
  // Bus is ours in every fetch state once the vector is in
  assign fetch_en = !bus_busy &&
                    (state_q inside {ST_FETCH_IR, ST_FETCH_PB_IMM, ST_FETCH_B2});

  // ------------------------------------------------------------
  // Classifier on the opcode byte still on the bus
  // ------------------------------------------------------------
  assign fc_alu_inh = din_u.alu.row inside {ROW_INH_A, ROW_INH_B};
  assign fc_two     = din_u.alu.row inside {ROW_BRANCH, ROW_IMM_A, ROW_IMM_B};
  assign fc_store   = (din == OP_STA_EXT) || (din == OP_STB_EXT);

  // Decode of the already captured opcode
  assign ir_alu_imm = ir_q.alu.row inside {ROW_IMM_A, ROW_IMM_B};
  assign ir_store   = ir_q.alu.row inside {ROW_EXT_A, ROW_EXT_B};

  always_comb begin
    state_next = state_q;
    unique case (state_q)
      ST_FETCH_WAIT:   if (vector_load) state_next = ST_FETCH_IR;
      ST_FETCH_IR:     if (fetch_en && (fc_two || fc_store)) state_next = ST_FETCH_PB_IMM;
      ST_FETCH_PB_IMM: state_next = ir_store ? ST_FETCH_B2 : ST_FETCH_IR;
      ST_FETCH_B2:     state_next = ST_FETCH_B3;
      ST_FETCH_B3:     state_next = ST_FETCH_IR;
      default:         state_next = ST_FETCH_WAIT;
    endcase
  end

  // ------------------------------------------------------------
  // Short branch decision, offset on din during PB fetch
  // ------------------------------------------------------------
  always_comb begin
    br_known = 1'b1;
    case (ir_q.branch.cond[3:1])
      3'd0:    br_flag = 1'b0;      // BRA / BRN
      3'd2:    br_flag = cc[CC_C];  // BCC / BCS
      3'd3:    br_flag = cc[CC_Z];  // BNE / BEQ
      3'd4:    br_flag = cc[CC_V];  // BVC / BVS
      3'd5:    br_flag = cc[CC_N];  // BPL / BMI
      default: begin
        br_flag  = 1'b0;
        br_known = 1'b0;
      end
    endcase
  end

  // Odd condition wants the flag set, even wants it clear
  assign br_taken  = (ir_q.branch.cls == ROW_BRANCH) && br_known &&
                     (br_flag ^ ~ir_q.branch.cond[0]);
  assign pc_inc    = pc_q + 16'd1;
  assign pc_branch = pc_inc + {{8{din[7]}}, din};

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state_q      <= ST_FETCH_WAIT;
      ir_q         <= OP_NOP;
      exec_valid_q <= 1'b0;
      pc_q         <= '0;
    end else begin
      state_q      <= state_next;
      // Execute follows the last byte of an ALU instruction
      exec_valid_q <= fetch_en &&
                      ((state_q == ST_FETCH_IR && fc_alu_inh) ||
                       (state_q == ST_FETCH_PB_IMM && ir_alu_imm));
      if (fetch_en && state_q == ST_FETCH_IR) begin
        ir_q <= din_u;
      end
      if (vector_load) begin
        pc_q <= vector;
      end else if (fetch_en) begin
        pc_q <= (state_q == ST_FETCH_PB_IMM && br_taken) ? pc_branch : pc_inc;
      end
    end
  end

  // Operand and address bytes
  always_ff @(posedge clk) begin
    if (fetch_en && state_q == ST_FETCH_PB_IMM) begin
      pb_q <= din;
    end
    if (fetch_en && state_q == ST_FETCH_B2) begin
      fetch2_q <= din;
    end
  end

  assign pc        = pc_q;
  assign exec_req  = '{valid: exec_valid_q, opcode: ir_q, operand: pb_q};
  // Big-endian effective address, write lands while in B3
  assign store_req = '{valid: state_q == ST_FETCH_B3,
                       use_b: ir_q.alu.row == ROW_EXT_B,
                       ea:    {pb_q, fetch2_q}};

  a_state_onehot: assert property (@(posedge clk) disable iff (!reset_b)
    $onehot(state_q));

  a_req_exclusive: assert property (@(posedge clk) disable iff (!reset_b)
    !(exec_req.valid && store_req.valid));

endmodule

`default_nettype wire

// ==== hdl/exec_unit.sv ====
// Execution unit
// Decodes ALU rows and ops, holds A, B and CC, feeds the ALU
// and supplies the register value for store cycles
`default_nettype none

module exec_unit import core6809_pkg::*; (
  input  wire             clk,
  input  wire             reset_b,
  input  wire exec_req_t  exec_req,
  input  wire             store_use_b,
  output byte_t           cc,
  output byte_t           store_data
);

  byte_t      a_q;
  byte_t      b_q;
  byte_t      cc_q;
  byte_t      cc_next;
  byte_t      alu_in_a;
  byte_t      alu_in_b;
  byte_t      alu_result;
  alu_flags_t alu_flags;
  logic [3:0] op;
  logic       row_ok;
  logic       is_imm;
  logic       use_b;
  logic       op_known;
  logic       alu_hot;
  logic       dest_a;
  logic       dest_b;

  // ------------------------------------------------------------
  // Row and op decode, alu view of the opcode
  // ------------------------------------------------------------
  assign op     = exec_req.opcode.alu.op;
  assign row_ok = exec_req.opcode.alu.row inside {ROW_INH_A, ROW_INH_B, ROW_IMM_A, ROW_IMM_B};
  assign is_imm = exec_req.opcode.alu.row inside {ROW_IMM_A, ROW_IMM_B};
  assign use_b  = exec_req.opcode.alu.row inside {ROW_INH_B, ROW_IMM_B};

  always_comb begin
    op_known = 1'b0;
    if (is_imm) begin
      case (op)
        ALU_SUB, ALU_SBC, ALU_AND, ALU_LD,
        ALU_EOR, ALU_ADC, ALU_OR, ALU_ADD: op_known = 1'b1;
        default:                           op_known = 1'b0;
      endcase
    end else begin
      case (op)
        INH_NEG, INH_COM, INH_LSR, INH_DEC,
        INH_INC, INH_TST, INH_CLR:         op_known = 1'b1;
        default:                           op_known = 1'b0;
      endcase
    end
  end

  assign alu_hot = exec_req.valid && row_ok && op_known;
  // TST only touches the flags
  assign dest_a  = alu_hot && !use_b && !(!is_imm && op == INH_TST);
  assign dest_b  = alu_hot &&  use_b && !(!is_imm && op == INH_TST);

  // Accumulator on the left, immediate on the right
  assign alu_in_a = use_b ? b_q : a_q;
  assign alu_in_b = is_imm ? exec_req.operand : 8'h00;

  alu8 u_alu8 (
    .in_a   (alu_in_a),
    .in_b   (alu_in_b),
    .opcode (exec_req.opcode),
    .cc_in  (cc_q),
    .result (alu_result),
    .flags  (alu_flags)
  );

  // E, F and I are left alone
  always_comb begin
    cc_next = cc_q;
    if (alu_hot) begin
      cc_next[CC_H] = alu_flags.h;
      cc_next[CC_N] = alu_flags.n;
      cc_next[CC_Z] = alu_flags.z;
      cc_next[CC_V] = alu_flags.v;
      cc_next[CC_C] = alu_flags.c;
    end
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a_q  <= 8'h00;
      b_q  <= 8'h00;
      cc_q <= CC_RESET;
    end else begin
      cc_q <= cc_next;
      if (dest_a) a_q <= alu_result;
      if (dest_b) b_q <= alu_result;
    end
  end

  assign cc         = cc_q;
  assign store_data = store_use_b ? b_q : a_q;

  // At most one accumulator changes per cycle
  a_single_dest: assert property (@(posedge clk) disable iff (!reset_b)
    !((a_q != $past(a_q)) && (b_q != $past(b_q))));

endmodule

`default_nettype wire

// ==== hdl/bus_unit.sv ====
// Load/store unit
// Fetches the reset vector, stages its MSB and drives store cycles;
// hands the address bus to the PC whenever it is idle
`default_nettype none

module bus_unit import core6809_pkg::*; (
  input  wire              clk,
  input  wire              reset_b,
  input  wire store_req_t  store_req,
  input  wire byte_t       store_data,
  input  wire addr_t       pc,
  input  wire byte_t       din,
  output addr_t            addr,
  output logic             data_rw_n,
  output byte_t            data_out,
  output logic             bus_busy,
  output logic             vector_load,
  output addr_t            vector
);

  typedef enum logic [1:0] {
    LSU_VEC_MSB,
    LSU_VEC_LSB,
    LSU_IDLE,
    LSU_WRITE
  } lsu_state_t;

  lsu_state_t lsu_q;
  lsu_state_t lsu_state;
  byte_t      vec_msb_q;

  // Store request arrives in the cycle it must be written
  assign lsu_state = (lsu_q == LSU_IDLE && store_req.valid) ? LSU_WRITE : lsu_q;

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      lsu_q <= LSU_VEC_MSB;
    end else begin
      lsu_q <= (lsu_q == LSU_VEC_MSB) ? LSU_VEC_LSB : LSU_IDLE;
    end
  end

  // Vector high byte, big-endian
  always_ff @(posedge clk) begin
    if (lsu_q == LSU_VEC_MSB) vec_msb_q <= din;
  end

  // ------------------------------------------------------------
  // Address mux
  // ------------------------------------------------------------
  always_comb begin
    case (lsu_state)
      LSU_VEC_MSB: addr = RESET_VECTOR;
      LSU_VEC_LSB: addr = RESET_VECTOR + 16'd1;
      LSU_WRITE:   addr = store_req.ea;
      default:     addr = pc;
    endcase
  end

  assign data_rw_n   = (lsu_state != LSU_WRITE);
  assign data_out    = store_data;
  assign bus_busy    = (lsu_state != LSU_IDLE);
  assign vector_load = (lsu_q == LSU_VEC_LSB);
  assign vector      = {vec_msb_q, din};

  a_write_one_cycle: assert property (@(posedge clk) disable iff (!reset_b)
    !data_rw_n |-> (lsu_q == LSU_IDLE) ##1 data_rw_n);

endmodule

`default_nettype wire

// ==== hdl/core6809.sv ====
// 6809 compatible CPU core, reduced subset
// Big-endian, one bus cycle per clock, combinational read data
// Connects the fetch controller, execution unit and bus unit
`default_nettype none

module core6809 import core6809_pkg::*; (
  input  wire          clk,
  input  wire          reset_b,
  output addr_t        addr,
  output logic         data_rw_n,
  input  wire byte_t   din,
  output byte_t        data_out
);

  // Fetch to execute and fetch to bus requests
  exec_req_t  exec_req;
  store_req_t store_req;

  // Feedback into fetch
  byte_t cc;
  addr_t pc;
  logic  bus_busy;
  logic  vector_load;
  addr_t vector;

  // Register picked for the store cycle
  byte_t store_data;

  // ------------------------------------------------------------
  // Instruction fetch, PC and branches
  // ------------------------------------------------------------
  fetch_ctrl u_fetch_ctrl (
    .clk         (clk),
    .reset_b     (reset_b),
    .din         (din),
    .bus_busy    (bus_busy),
    .vector_load (vector_load),
    .vector      (vector),
    .cc          (cc),
    .pc          (pc),
    .exec_req    (exec_req),
    .store_req   (store_req)
  );

  // Accumulators, CC and the ALU
  exec_unit u_exec_unit (
    .clk         (clk),
    .reset_b     (reset_b),
    .exec_req    (exec_req),
    .store_use_b (store_req.use_b),
    .cc          (cc),
    .store_data  (store_data)
  );

  // Owner of the external bus
  bus_unit u_bus_unit (
    .clk         (clk),
    .reset_b     (reset_b),
    .store_req   (store_req),
    .store_data  (store_data),
    .pc          (pc),
    .din         (din),
    .addr        (addr),
    .data_rw_n   (data_rw_n),
    .data_out    (data_out),
    .bus_busy    (bus_busy),
    .vector_load (vector_load),
    .vector      (vector)
  );

endmodule

`default_nettype wire

// ==== tb/core_checker.sv ====
// Bus write checker for the 6809 core subset
// Compares every write cycle against the expected list of a test
// and keeps per-test and total failure counts
`default_nettype none

module core_checker import core6809_pkg::*; (
  input  wire          clk,
  input  wire          reset_b,
  input  wire addr_t   addr,
  input  wire          data_rw_n,
  input  wire byte_t   data_out,
  output int           tests_run,
  output int           tests_failed
);

  addr_t exp_addr[$];
  byte_t exp_data[$];
  addr_t want_addr;
  byte_t want_data;
  string test_name;
  int    test_errs;

  initial begin
    tests_run    = 0;
    tests_failed = 0;
    test_errs    = 0;
    test_name    = "none";
  end

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic expect_write(input addr_t a, input byte_t d);
    exp_addr.push_back(a);
    exp_data.push_back(d);
  endtask

  // Leftover entries mean writes that never came
  task automatic end_test();
    if (exp_addr.size() != 0) begin
      $display("%s: %0d expected write(s) never happened", test_name, exp_addr.size());
      test_errs++;
    end
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %s: %s (%0d errors)", test_name, (test_errs == 0) ? "passed" : "failed",
             test_errs);
  endtask

  // ------------------------------------------------------------
  // Write cycle compare, one entry per low strobe cycle
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (reset_b && !data_rw_n) begin
      if (exp_addr.size() == 0) begin
        $display("%s: extra write of %h at address %h", test_name, data_out, addr);
        test_errs++;
      end else begin
        want_addr = exp_addr.pop_front();
        want_data = exp_data.pop_front();
        if (addr !== want_addr) begin
          $display("[ERROR] %s: write address expected %h actual %h", test_name, want_addr,
                   addr);
          test_errs++;
        end
        if (data_out !== want_data) begin
          $display("[ERROR] %s: write data expected %h actual %h", test_name, want_data,
                   data_out);
          test_errs++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_core6809.sv ====
// Testbench for the 6809 core subset
// Memory model, program builder, reference instruction model,
// test sequence and watchdog
`default_nettype none

module tb_core6809 import core6809_pkg::*;;

  localparam int NUM_TESTS = 5;

  logic  clk;
  logic  reset_b;
  addr_t addr;
  logic  data_rw_n;
  byte_t din;
  byte_t data_out;
  int    tests_run;
  int    tests_failed;

  byte_t mem [0:65535];
  addr_t pc_w;
  addr_t org;
  addr_t halt_pc;
  addr_t exp_a[$];
  byte_t exp_d[$];

  // Combinational read, data valid with the address
  assign din = mem[addr];

  core6809 DUT (
    .clk       (clk),
    .reset_b   (reset_b),
    .addr      (addr),
    .data_rw_n (data_rw_n),
    .din       (din),
    .data_out  (data_out)
  );

  core_checker u_checker (
    .clk          (clk),
    .reset_b      (reset_b),
    .addr         (addr),
    .data_rw_n    (data_rw_n),
    .data_out     (data_out),
    .tests_run    (tests_run),
    .tests_failed (tests_failed)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Hang guard sized from the test count
  initial begin
    repeat (NUM_TESTS * 200) @(posedge clk);
    $display("watchdog expired, a program never reached its final loop");
    $display("SOME TESTS FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // Program builder
  // ------------------------------------------------------------
  task automatic emit(input byte_t b);
    mem[pc_w] = b;
    pc_w      = pc_w + 16'd1;
  endtask

  task automatic emit2(input byte_t op, input byte_t b);
    emit(op);
    emit(b);
  endtask

  task automatic emit_store(input logic use_b, input addr_t ea);
    emit(use_b ? OP_STB_EXT : OP_STA_EXT);
    emit(ea[15:8]);
    emit(ea[7:0]);
  endtask

  task automatic begin_prog(input addr_t start);
    org       = start;
    pc_w      = start;
    mem[16'hFFFE] = start[15:8];
    mem[16'hFFFF] = start[7:0];
  endtask

  // BRA to itself ends the program
  task automatic emit_halt();
    halt_pc = pc_w;
    emit2(8'h20, 8'hFE);
  endtask

  // ------------------------------------------------------------
  // Reference model of the instruction subset
  // ------------------------------------------------------------
  function automatic void ref_run(input addr_t start);
    addr_t      p;
    addr_t      np;
    byte_t      a;
    byte_t      b;
    byte_t      x;
    byte_t      m;
    byte_t      op;
    byte_t      r;
    logic [8:0] w;
    logic       n;
    logic       z;
    logic       v;
    logic       c;
    logic       take;
    logic       done;
    int         steps;
    p = start;
    a = 8'h00;
    b = 8'h00;
    {n, z, v, c} = 4'b0000;
    done  = 1'b0;
    steps = 0;
    exp_a.delete();
    exp_d.delete();
    while (!done && steps < 2000) begin
      op = mem[p];
      m  = mem[p + 16'd1];
      x  = (op[7:4] inside {4'h5, 4'hC, 4'hF}) ? b : a;
      r  = x;
      steps++;
      case (op[7:4])
        4'h2: begin
          case (op[3:0])
            4'h0:    take = 1'b1;
            4'h4:    take = !c;
            4'h5:    take = c;
            4'h6:    take = !z;
            4'h7:    take = z;
            4'h8:    take = !v;
            4'h9:    take = v;
            4'hA:    take = !n;
            4'hB:    take = n;
            default: take = 1'b0;
          endcase
          np = p + 16'd2 + {{8{m[7]}}, m};
          if (take && np == p) done = 1'b1;
          p = take ? np : p + 16'd2;
        end
        4'h4, 4'h5: begin
          case (op[3:0])
            4'h0: begin
              r = 8'h00 - x;
              v = (x == 8'h80);
              c = (x != 8'h00);
            end
            4'h3: begin
              r = ~x;
              v = 1'b0;
              c = 1'b1;
            end
            4'h4: begin
              r = x >> 1;
              c = x[0];
            end
            4'hA: begin
              r = x - 8'd1;
              v = (x == 8'h80);
            end
            4'hC: begin
              r = x + 8'd1;
              v = (x == 8'h7F);
            end
            4'hF: begin
              r = 8'h00;
              v = 1'b0;
              c = 1'b0;
            end
            default: v = 1'b0;  // TST
          endcase
          n = r[7];
          z = (r == 8'h00);
          if (op[3:0] != 4'hD) begin
            if (op[4]) b = r;
            else a = r;
          end
          p = p + 16'd1;
        end
        4'h8, 4'hC: begin
          case (op[3:0])
            4'h0, 4'h2: begin
              w = {1'b0, x} - {1'b0, m} - ((op[3:0] == 4'h2) ? {8'h00, c} : 9'd0);
              r = w[7:0];
              c = w[8];
              v = (x[7] != m[7]) && (r[7] != x[7]);
            end
            4'h9, 4'hB: begin
              w = {1'b0, x} + {1'b0, m} + ((op[3:0] == 4'h9) ? {8'h00, c} : 9'd0);
              r = w[7:0];
              c = w[8];
              v = (x[7] == m[7]) && (r[7] != x[7]);
            end
            4'h4:    r = x & m;
            4'h6:    r = m;
            4'h8:    r = x ^ m;
            default: r = x | m;
          endcase
          if (op[3:0] inside {4'h4, 4'h6, 4'h8, 4'hA}) v = 1'b0;
          n = r[7];
          z = (r == 8'h00);
          if (op[6]) b = r;
          else a = r;
          p = p + 16'd2;
        end
        4'hB, 4'hF: begin
          exp_a.push_back({m, mem[p + 16'd2]});
          exp_d.push_back(x);
          p = p + 16'd3;
        end
        default: p = p + 16'd1;
      endcase
    end
  endfunction

  task automatic hold_reset();
    @(negedge clk);
    reset_b = 1'b0;
  endtask

  // Predict, release reset, wait for the final loop
  task automatic run_test(input string name);
    ref_run(org);
    u_checker.start_test(name);
    foreach (exp_a[i]) u_checker.expect_write(exp_a[i], exp_d[i]);
    repeat (4) @(negedge clk);
    reset_b = 1'b1;
    while (addr !== halt_pc) @(negedge clk);
    repeat (4) @(negedge clk);
    u_checker.end_test();
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    byte_t imm_ops[8];
    byte_t inh_ops[7];
    byte_t edge_vals[3];
    byte_t conds[10];
    byte_t setup_a[2];
    byte_t setup_b[2];
    void'($urandom(32'haddb));
    imm_ops   = '{8'h0, 8'h2, 8'h4, 8'h6, 8'h8, 8'h9, 8'hA, 8'hB};
    inh_ops   = '{8'h0, 8'h3, 8'h4, 8'hA, 8'hC, 8'hD, 8'hF};
    edge_vals = '{8'h7F, 8'h80, 8'h00};
    conds     = '{8'h0, 8'h1, 8'h4, 8'h5, 8'h6, 8'h7, 8'h8, 8'h9, 8'hA, 8'hB};
    // 01+FF leaves Z and C set, 40+40 leaves N and V set
    setup_a   = '{8'h01, 8'h40};
    setup_b   = '{8'hFF, 8'h40};
    reset_b = 1'b0;
    for (int i = 0; i < 65536; i++) mem[i] = byte_t'(i[15:8] ^ i[7:0] ^ 8'h5A);

    hold_reset();
    begin_prog(16'h1000 + addr_t'($urandom() & 32'h2FFF));
    emit2(8'h86, byte_t'($urandom()));
    emit_store(1'b0, 16'h4000);
    emit_halt();
    run_test("reset_vector");

    hold_reset();
    begin_prog(16'h0100);
    emit2(8'h86, byte_t'($urandom()));
    emit2(8'hC6, byte_t'($urandom()));
    foreach (imm_ops[i]) begin
      emit2(8'h80 | imm_ops[i], byte_t'($urandom()));
      emit_store(1'b0, 16'h4200 + addr_t'(2 * i));
      emit2(8'hC0 | imm_ops[i], byte_t'($urandom()));
      emit_store(1'b1, 16'h4201 + addr_t'(2 * i));
    end
    emit_halt();
    run_test("immediate_alu");

    hold_reset();
    begin_prog(16'h0100);
    foreach (edge_vals[v]) begin
      foreach (inh_ops[k]) begin
        emit2(8'h86, edge_vals[v]);
        emit(8'h40 | inh_ops[k]);
        emit_store(1'b0, 16'h4400 + addr_t'(16 * v + k));
        emit2(8'hC6, edge_vals[v]);
        emit(8'h50 | inh_ops[k]);
        emit_store(1'b1, 16'h4408 + addr_t'(16 * v + k));
      end
    end
    emit_halt();
    run_test("inherent_ops");

    // Marker store skipped when taken, join store always
    hold_reset();
    begin_prog(16'h0100);
    for (int rep = 0; rep < 2; rep++) begin
      foreach (conds[k]) begin
        emit2(8'h86, setup_a[rep]);
        emit2(8'h8B, setup_b[rep]);
        emit2(8'h20 | conds[k], 8'h03);
        emit_store(1'b0, 16'h5000 + addr_t'(64 * rep + 2 * k));
        emit_store(1'b0, 16'h5001 + addr_t'(64 * rep + 2 * k));
      end
    end
    emit_halt();
    run_test("branches");

    hold_reset();
    begin_prog(16'h0100);
    emit2(8'h86, byte_t'($urandom()));
    emit2(8'hC6, byte_t'($urandom()));
    emit_store(1'b0, 16'h6000);
    emit_store(1'b1, 16'h6001);
    emit_store(1'b1, 16'hA5F0);
    emit_store(1'b0, 16'h6000);
    emit(8'h4C);
    emit_store(1'b0, 16'h7FFF);
    emit_halt();
    run_test("store_cycles");

    $display("tests run %0d, tests failed %0d", tests_run, tests_failed);
    if (tests_failed == 0 && tests_run == NUM_TESTS) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/core6809_pkg.sv
hdl/alu8.sv
hdl/fetch_ctrl.sv
hdl/exec_unit.sv
hdl/bus_unit.sv
hdl/core6809.sv
tb/core_checker.sv
tb/tb_core6809.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core6809 \
  -f project.f -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0
